//--- runSim.sh
#!/bin/sh
# build and run the serialLink testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module serialLinkTb \
  --Mdir obj_dir

# keep running past assertion errors so the testbench can report them
./obj_dir/VserialLinkTb +verilator+error+limit+100 | tee sim.log

if grep -q "Testbench passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

//--- sim/serialLinkTb.sv
// serialLink testbench with clock, vector reader, LFSR stalls, scoreboard and check task
`timescale 1ns/1ps
`default_nettype none

module serialLinkTb;

  localparam int Width       = 8;
  localparam int VectorCount = 38;
  localparam int IndexWidth  = $clog2(VectorCount * 2);
  localparam int StallAfter  = 8;    // words taken before the long output stall
  localparam int StallCycles = 96;   // outReady held low this long
  localparam int DrainCycles = 200;  // quiet window, longer than one word on the line
  localparam int Timeout     = 1000; // cycles any single wait may last

  logic             clock;
  logic             resetQ;
  logic [Width-1:0] inData;
  logic             inValid;
  logic             inReady;
  logic [Width-1:0] outData;
  logic             outValid;
  logic             outReady;

  logic [Width-1:0] vectorMem [VectorCount*2]; // pairs of input word and expected word
  int               sentCount;                 // words the DUT accepted
  int               receivedCount;             // words taken at the output

  serialLink #(
    .Width(Width)
  ) dut0 (
    .clock   (clock),
    .resetQ  (resetQ),
    .inData  (inData),
    .inValid (inValid),
    .inReady (inReady),
    .outData (outData),
    .outValid(outValid),
    .outReady(outReady)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock; // 40 ns period
  end

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic takeBit(inout logic [31:0] state, output logic value);
    state = lfsrNext(state);
    value = state[0]; // fresh feedback bit
  endtask

  task automatic abortRun();
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      abortRun();
    end
  endtask

  // upstream side offers words at random and holds each until accepted
  task automatic produceWords();
    logic [31:0] lfsr;
    logic        offer;
    logic        acceptNext;
    int          waited;
    lfsr       = 32'he9df_fba6;
    acceptNext = 1'b0;
    waited     = 0;
    while (sentCount < VectorCount) begin
      @(negedge clock);
      if (acceptNext) begin // transfer happened on the last rising edge
        sentCount++;
        inValid = 1'b0;
        waited  = 0;
      end
      if (!inValid && (sentCount < VectorCount)) begin
        takeBit(lfsr, offer);
        if (offer) begin
          inValid = 1'b1;
          inData  = vectorMem[IndexWidth'(2 * sentCount)];
        end
      end
      acceptNext = inValid && inReady; // inReady only moves on the rising edge
      waited++;
      if (waited > Timeout) begin
        $display("timeout: the link did not accept input word %0d", sentCount);
        abortRun();
      end
    end
  endtask

  // long outReady low stretch where the output must freeze and the input must back up
  task automatic holdOffOutput();
    logic [Width-1:0] heldData;
    logic             fullSeen;
    int               waited;
    outReady = 1'b0;
    waited   = 0;
    while (!outValid) begin
      @(negedge clock);
      waited++;
      if (waited > Timeout) begin
        $display("timeout: no word showed up at the output before the stall");
        abortRun();
      end
    end
    heldData = outData;
    fullSeen = !inReady;
    for (int cycle = 0; cycle < StallCycles; cycle++) begin
      @(negedge clock);
      checkValue("outValid during stall", 32'd1, 32'(outValid));
      checkValue("outData during stall", 32'(heldData), 32'(outData));
      if (!inReady) fullSeen = 1'b1;
    end
    waited = 0;
    while (!fullSeen) begin // holding register should fill soon
      @(negedge clock);
      checkValue("outValid during stall", 32'd1, 32'(outValid));
      fullSeen = !inReady;
      waited++;
      if (waited > Timeout) begin
        $display("timeout: inReady never dropped while the output was stalled");
        abortRun();
      end
    end
  endtask

  // downstream side with random ready, one long stall and an in-order scoreboard
  task automatic consumeWords();
    logic [31:0] lfsr;
    logic        bitA;
    logic        bitB;
    logic        stalled;
    int          waited;
    int          step;
    lfsr    = 32'he9df_fba6;
    stalled = 1'b0;
    waited  = 0;
    for (step = 0; step < 16; step++) begin
      lfsr = lfsrNext(lfsr); // run ahead so ready is not a copy of valid
    end
    while (receivedCount < VectorCount) begin
      @(negedge clock);
      if ((receivedCount == StallAfter) && !stalled) begin
        stalled = 1'b1;
        holdOffOutput();
        waited = 0;
      end
      takeBit(lfsr, bitA);
      takeBit(lfsr, bitB);
      outReady = bitA | bitB; // ready about three cycles in four
      if (outValid && outReady) begin
        checkValue($sformatf("word %0d", receivedCount),
                   32'(vectorMem[IndexWidth'(2 * receivedCount + 1)]), 32'(outData));
        receivedCount++;
        waited = 0;
      end
      waited++;
      if (waited > Timeout) begin
        $display("timeout: output word %0d never arrived", receivedCount);
        abortRun();
      end
    end
  endtask

  // bound assertions bump a counter that is checked every cycle
  always @(negedge clock) begin
    checkValue("assertion failures", 32'd0, 32'(dut0.sva0.failCount));
  end

  initial begin
    resetQ        = 1'b1;
    inData        = '0;
    inValid       = 1'b0;
    outReady      = 1'b0;
    sentCount     = 0;
    receivedCount = 0;
    $readmemh("sim/serialLinkVectors.txt", vectorMem);
    repeat (2) @(posedge clock);
    @(negedge clock);
    resetQ = 1'b0;
    @(negedge clock);
    checkValue("inReady after reset", 32'd1, 32'(inReady));
    checkValue("outValid after reset", 32'd0, 32'(outValid));
    fork
      produceWords();
      consumeWords();
    join
    outReady = 1'b1;
    repeat (DrainCycles) begin // a duplicate word still gets counted here
      @(negedge clock);
      if (outValid) begin
        receivedCount++; // taken on the next rising edge
      end
    end
    checkValue("accepted vs received count", 32'(sentCount), 32'(receivedCount));
    if (dut0.sva0.failCount == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("%0d assertion failures were seen", dut0.sva0.failCount);
      abortRun();
    end
  end

endmodule : serialLinkTb

`default_nettype wire

//--- sim/serialLinkVectors.txt
// columns: input word, expected received word (hex), one pair per line
// edge patterns for bit order and rail choice come first
00 00
FF FF
01 01
80 80
55 55
AA AA
0F 0F
F0 F0
3C 3C
C3 C3
12 12
34 34
56 56
78 78
9A 9A
BC BC
DE DE
F1 F1
7E 7E
81 81
A5 A5
5A 5A
02 02
40 40
FE FE
7F 7F
11 11
22 22
44 44
88 88
E7 E7
18 18
99 99
66 66
C0 C0
03 03
B4 B4
4B 4B

//--- sim/serialLink_sva.sv
// concurrent assertions on the dual-rail line and the output handshake, bound to serialLink
`timescale 1ns/1ps
`default_nettype none

module serialLinkSva import serialLinkPkg::*; #(
  parameter int Width = DefaultWidth
) (
  input  wire logic             clock,
  input  wire logic             resetQ,
  input  wire lineT             lineData,
  input  wire txStateT          txState,  // from the transmitter FSM
  input  wire logic [Width-1:0] outData,
  input  wire logic             outValid,
  input  wire logic             outReady
);

  int failCount = 0; // bumped by every failing assertion

  // one rail per data bit, never both at once
  lineOneRail: assert property (@(posedge clock) disable iff (resetQ)
    $countones(lineData ^ $past(lineData)) <= 1)
    else begin
      $error("lineData changed more than one bit in a cycle");
      failCount++;
    end

  lineQuietInWait: assert property (@(posedge clock) disable iff (resetQ)
    (txState == TxWaitAck) |=> $stable(lineData)) // line frozen until the ack parity matches
    else begin
      $error("lineData moved while the transmitter waited for ack");
      failCount++;
    end

  outDataStable: assert property (@(posedge clock) disable iff (resetQ)
    (outValid && !outReady) |=> $stable(outData))
    else begin
      $error("outData changed while stalled");
      failCount++;
    end

  outValidHeld: assert property (@(posedge clock) disable iff (resetQ)
    (outValid && !outReady) |=> outValid) // no word dropped before acceptance
    else begin
      $error("outValid fell before the word was accepted");
      failCount++;
    end

endmodule : serialLinkSva

bind serialLink serialLinkSva #(
  .Width(Width)
) sva0 (
  .clock   (clock),
  .resetQ  (resetQ),
  .lineData(lineData),
  .txState (transmitter0.txState),
  .outData (outData),
  .outValid(outValid),
  .outReady(outReady)
);

`default_nettype wire

//--- source/bitSynchronizer.sv
// multi-flop synchronizer for asynchronous line inputs
`timescale 1ns/1ps
`default_nettype none

module bitSynchronizer #(
  parameter int Width  = 1,
  parameter int Stages = 2
) (
  input  wire logic             clock,
  input  wire logic [Width-1:0] in,
  output logic      [Width-1:0] out
);

  logic [Width-1:0] syncChain [Stages]; // [0] samples the async input

  // no reset here, a cleared chain would look like a toggle to the far end
  always_ff @(posedge clock) begin
    syncChain[0] <= in;
    for (int i = 1; i < Stages; i++) begin
      syncChain[i] <= syncChain[i-1]; // one more flop per stage
    end
  end

  assign out = syncChain[Stages-1]; // last stage is safe to use

endmodule : bitSynchronizer

`default_nettype wire

//--- source/serialLink.sv
// top level: transmitter and receiver joined by the dual-rail line
`timescale 1ns/1ps
`default_nettype none

module serialLink import serialLinkPkg::*; #(
  parameter int Width = DefaultWidth
) (
  input  wire logic             clock,
  input  wire logic             resetQ,
  // upstream words
  input  wire logic [Width-1:0] inData,
  input  wire logic             inValid,
  output logic                  inReady,
  // downstream words
  output logic      [Width-1:0] outData,
  output logic                  outValid,
  input  wire logic             outReady
);

  lineT lineData; // tx -> rx toggles
  logic lineAck;  // rx -> tx parity ack

  serialTransmitter #(
    .Width     (Width),
    .SyncStages(DefaultSyncStages)
  ) transmitter0 (
    .clock   (clock),
    .resetQ  (resetQ),
    .inData  (inData),
    .inValid (inValid),
    .inReady (inReady),
    .lineData(lineData),
    .lineAck (lineAck)
  );

  // same depth at both ends so the round trip is symmetric
  serialReceiver #(
    .Width     (Width),
    .SyncStages(DefaultSyncStages)
  ) receiver0 (
    .clock   (clock),
    .resetQ  (resetQ),
    .lineData(lineData),
    .lineAck (lineAck),
    .outData (outData),
    .outValid(outValid),
    .outReady(outReady)
  );

endmodule : serialLink

`default_nettype wire

//--- source/serialLinkPkg.sv
// line type, transmitter state type, default word width and synchronizer depth
`default_nettype none

package serialLinkPkg;

  // dual-rail line: bit 0 toggles for a zero, bit 1 toggles for a one
  typedef logic [1:0] lineT;

  // transmitter FSM
  typedef enum logic [1:0] {
    TxIdle,    // waiting for a word in the holding register
    TxSend,    // toggle one rail for the current bit
    TxWaitAck  // wait for ack parity to catch up with the line
  } txStateT;

  localparam int DefaultWidth      = 8; // word width unless the top says otherwise
  localparam int DefaultSyncStages = 2; // flops per synchronizer chain

endpackage : serialLinkPkg

`default_nettype wire

//--- source/serialReceiver.sv
// serial receiver: toggle decoder, word assembly and valid/ready output
`timescale 1ns/1ps
`default_nettype none

module serialReceiver import serialLinkPkg::*; #(
  parameter int Width      = DefaultWidth,
  parameter int SyncStages = DefaultSyncStages
) (
  input  wire logic             clock,
  input  wire logic             resetQ,
  input  wire lineT             lineData,
  output logic                  lineAck,
  output logic      [Width-1:0] outData,
  output logic                  outValid,
  input  wire logic             outReady
);

  localparam int CountWidth = (Width > 1) ? $clog2(Width) : 1;

  lineT                  lineSync;  // line after the synchronizer
  lineT                  lineSyncQ; // previous synchronized sample
  logic [CountWidth-1:0] bitCount;
  logic                  bitValid;
  logic                  bitValue;

  bitSynchronizer #(
    .Width ($bits(lineT)),
    .Stages(SyncStages)
  ) lineSync0 (
    .clock(clock),
    .in   (lineData),
    .out  (lineSync)
  );

  // parity of the line moved away from our ack, so one rail toggled
  assign bitValid = (lineAck != ^lineSync);
  assign bitValue = lineSyncQ[1] ^ lineSync[1]; // rail 1 moved means a one

  always_ff @(posedge clock) begin
    if (resetQ) begin
      outValid <= 1'b0;
      bitCount <= '0;
      lineAck  <= ^lineSync; // lock onto whatever the line shows now
    end else begin
      if (outValid) begin
        if (outReady) begin
          outValid <= 1'b0;
          lineAck  <= ^lineSync; // last bit acked only once the word has left
        end
      end else if (bitValid) begin
        outData <= {bitValue, outData[Width-1:1]}; // lsb first, enters at the top
        if (bitCount == CountWidth'(Width - 1)) begin
          outValid <= 1'b1;
          bitCount <= '0;
          // hold the ack, this is the back-pressure path
        end else begin
          lineAck  <= ^lineSync;
          bitCount <= bitCount + 1'b1;
        end
      end
    end
  end

  // edge reference for bit decode, runs through reset
  always_ff @(posedge clock) begin
    lineSyncQ <= lineSync;
  end

endmodule : serialReceiver

`default_nettype wire

//--- source/serialTransmitter.sv
// serial transmitter: holding register, shift register and dual-rail toggle FSM
`timescale 1ns/1ps
`default_nettype none

module serialTransmitter import serialLinkPkg::*; #(
  parameter int Width      = DefaultWidth,
  parameter int SyncStages = DefaultSyncStages
) (
  input  wire logic             clock,
  input  wire logic             resetQ,
  input  wire logic [Width-1:0] inData,
  input  wire logic             inValid,
  output logic                  inReady,
  output lineT                  lineData,
  input  wire logic             lineAck
);

  localparam int CountWidth = (Width > 1) ? $clog2(Width) : 1;

  txStateT               txState;
  logic [Width-1:0]      holdData;  // one word buffered ahead of the line
  logic                  holdFull;
  logic [Width-1:0]      shiftData; // low bit goes out next
  logic [CountWidth-1:0] bitCount;
  logic                  ackSync;
  logic                  ackDone;

  // ack comes from the receiver, possibly another domain
  bitSynchronizer #(
    .Width (1),
    .Stages(SyncStages)
  ) ackSync0 (
    .clock(clock),
    .in   (lineAck),
    .out  (ackSync)
  );

  assign inReady = !holdFull;               // only stalls when the buffer is occupied
  assign ackDone = (ackSync == ^lineData);  // receiver has consumed the last toggle

  // upstream side, fills the holding register whenever it is empty
  always_ff @(posedge clock) begin
    if (resetQ) begin
      holdFull <= 1'b0;
    end else begin
      if (inValid && inReady) begin
        holdData <= inData;
        holdFull <= 1'b1;
      end else if ((txState == TxIdle) && holdFull) begin
        holdFull <= 1'b0; // FSM takes the word this cycle
      end
    end
  end

  // line side FSM
  always_ff @(posedge clock) begin
    if (resetQ) begin
      txState  <= TxIdle;
      bitCount <= '0;
      // lineData keeps its value so the receiver can lock onto it
    end else begin
      case (txState)
        TxIdle: begin
          if (holdFull) begin
            shiftData <= holdData;
            bitCount  <= '0;
            txState   <= TxSend;
          end
        end
        TxSend: begin
          // one rail flips per bit, rail 1 for a one
          lineData  <= lineData ^ (shiftData[0] ? lineT'(2'b10) : lineT'(2'b01));
          shiftData <= shiftData >> 1;
          txState   <= TxWaitAck;
        end
        TxWaitAck: begin
          if (ackDone) begin
            if (bitCount == CountWidth'(Width - 1)) begin
              bitCount <= '0;
              txState  <= TxIdle; // word done
            end else begin
              bitCount <= bitCount + 1'b1;
              txState  <= TxSend;
            end
          end
        end
        default: txState <= TxIdle;
      endcase
    end
  end

endmodule : serialTransmitter

`default_nettype wire

//--- verilog.f
source/serialLinkPkg.sv
source/bitSynchronizer.sv
source/serialTransmitter.sv
source/serialReceiver.sv
source/serialLink.sv
sim/serialLink_sva.sv
sim/serialLinkTb.sv
